// ==== files.f ====
dbg_pkg.sv
tx_byte_if.sv
uart_rx.sv
uart_tx.sv
dbg_command_decoder.sv
dbg_snapshot_sequencer.sv
uart_debug_port.sv
tb_uart_debug_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart debug port testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_uart_debug_port -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished without errors"
exit 0

// ==== tb_uart_debug_port.sv ====
module tb_uart_debug_port;
    import dbg_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam int RESET_CHECK_CYCLES = 50;
    localparam int SILENCE_CYCLES = 2 * SNAPSHOT_PERIOD;
    localparam int START_TIMEOUT = 2 * SNAPSHOT_PERIOD;
    localparam int ECHO_TIMEOUT = 12 * TICKS_PER_BIT;

    typedef enum int {
        SEND_CMD,
        EXPECT_SNAPSHOT,
        EXPECT_SILENCE
    } action_e;

    logic                  clk_in = 1'b0;
    logic                  reset;
    logic [DATA_WIDTH-1:0] i_data;
    logic                  i_rx;
    logic                  o_tx;
    logic [7:0]            o_cmd_data;
    logic                  o_cmd_valid;
    logic                  o_rx_busy;

    // stimulus table, one entry per step
    action_e               row_action [NUM_ROWS];
    logic [7:0]            row_cmd    [NUM_ROWS];
    logic [DATA_WIDTH-1:0] row_word   [NUM_ROWS];
    logic                  row_change [NUM_ROWS];
    integer                seed;

    uart_debug_port i_uart_debug_port (
        .clk_in      (clk_in),
        .reset       (reset),
        .i_data      (i_data),
        .i_rx        (i_rx),
        .o_tx        (o_tx),
        .o_cmd_data  (o_cmd_data),
        .o_cmd_valid (o_cmd_valid),
        .o_rx_busy   (o_rx_busy)
    );

    initial begin
        forever #20 clk_in = ~clk_in;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic set_row(input int idx, input action_e action, input logic [7:0] cmd,
                           input logic [DATA_WIDTH-1:0] word, input logic change);
        row_action[idx] = action;
        row_cmd[idx]    = cmd;
        row_word[idx]   = word;
        row_change[idx] = change;
    endtask

    task automatic fill_table();
        logic [DATA_WIDTH-1:0] word_a;
        logic [DATA_WIDTH-1:0] word_b;
        logic [DATA_WIDTH-1:0] word_c;
        logic [DATA_WIDTH-1:0] word_d;
        logic [DATA_WIDTH-1:0] word_e;
        word_a = DATA_WIDTH'($random(seed));
        word_b = DATA_WIDTH'($random(seed));
        word_c = DATA_WIDTH'($random(seed));
        word_d = DATA_WIDTH'($random(seed));
        word_e = DATA_WIDTH'($random(seed));
        // first periodic snapshot, data changes once the first byte is out
        set_row(0, EXPECT_SNAPSHOT, 8'h00, word_a, 1'b1);
        set_row(1, SEND_CMD,        8'h50, word_b, 1'b0);
        set_row(2, EXPECT_SILENCE,  8'h00, word_b, 1'b0);
        // one-shot request while paused
        set_row(3, SEND_CMD,        8'h53, word_c, 1'b0);
        set_row(4, EXPECT_SNAPSHOT, 8'h00, word_c, 1'b0);
        set_row(5, EXPECT_SILENCE,  8'h00, word_c, 1'b0);
        // 'A' is no command and must leave the port paused
        set_row(6, SEND_CMD,        8'h41, word_d, 1'b0);
        set_row(7, EXPECT_SILENCE,  8'h00, word_d, 1'b0);
        set_row(8, SEND_CMD,        8'h52, word_e, 1'b0);
        set_row(9, EXPECT_SNAPSHOT, 8'h00, word_e, 1'b1);
    endtask

    // host side, one bit every TICKS_PER_BIT falling edges
    task automatic send_serial(input logic [7:0] value);
        int bit_num;
        i_rx = 1'b0;
        repeat (TICKS_PER_BIT) @(negedge clk_in);
        for (bit_num = 0; bit_num < 8; bit_num++) begin
            i_rx = value[bit_num];
            repeat (TICKS_PER_BIT) @(negedge clk_in);
        end
        // receiver is still inside the frame here
        compare_values("receiver busy during frame", 32'd1, 32'(o_rx_busy));
        // stop bit stays on the line while the echo is checked
        i_rx = 1'b1;
    endtask

    task automatic check_echo(input logic [7:0] cmd);
        int waited;
        waited = 0;
        while (o_cmd_valid !== 1'b1) begin
            if (waited == ECHO_TIMEOUT) begin
                abort_run("timeout: o_cmd_valid never pulsed after a command byte");
            end
            waited++;
            @(negedge clk_in);
        end
        compare_values("command echo data", 32'(cmd), 32'(o_cmd_data));
        compare_values("receiver busy at end of frame", 32'd0, 32'(o_rx_busy));
        @(negedge clk_in);
        compare_values("command echo single pulse", 32'd0, 32'(o_cmd_valid));
    endtask

    // waits for a start bit, then samples every bit at its middle
    task automatic receive_byte(input logic change_data, output logic [7:0] value);
        int                    waited;
        int                    bit_num;
        logic [DATA_WIDTH-1:0] start_word;
        waited = 0;
        while (o_tx !== 1'b0) begin
            if (waited == START_TIMEOUT) begin
                abort_run("timeout: no start bit appeared on o_tx");
            end
            waited++;
            @(negedge clk_in);
        end
        start_word = i_data;
        if (change_data) begin
            i_data = ~start_word;
        end
        repeat (HALF_BIT_TICKS) @(negedge clk_in);
        compare_values("start bit level", 32'd0, 32'(o_tx));
        for (bit_num = 0; bit_num < 8; bit_num++) begin
            repeat (TICKS_PER_BIT) @(negedge clk_in);
            value[bit_num] = o_tx;
        end
        repeat (TICKS_PER_BIT) @(negedge clk_in);
        compare_values("stop bit level", 32'd1, 32'(o_tx));
    endtask

    // msb first, then the newline byte
    task automatic check_snapshot(input logic [DATA_WIDTH-1:0] word, input logic change_data);
        logic [7:0] value;
        logic [7:0] expected;
        int         idx;
        for (idx = 0; idx < BYTES_PER_WORD; idx++) begin
            receive_byte(change_data && (idx == 0), value);
            expected = 8'(word >> (8 * (BYTES_PER_WORD - 1 - idx)));
            compare_values($sformatf("snapshot byte %0d", idx), 32'(expected), 32'(value));
        end
        receive_byte(1'b0, value);
        compare_values("snapshot newline", 32'h0A, 32'(value));
    endtask

    task automatic check_silence();
        int cycle;
        for (cycle = 0; cycle < SILENCE_CYCLES; cycle++) begin
            @(negedge clk_in);
            compare_values("o_tx idle while no snapshot is due", 32'd1, 32'(o_tx));
        end
    endtask

    task automatic check_reset_state();
        int cycle;
        for (cycle = 0; cycle < RESET_CHECK_CYCLES; cycle++) begin
            compare_values("o_tx after reset", 32'd1, 32'(o_tx));
            compare_values("o_cmd_valid after reset", 32'd0, 32'(o_cmd_valid));
            compare_values("o_rx_busy after reset", 32'd0, 32'(o_rx_busy));
            @(negedge clk_in);
        end
    endtask

    initial begin
        int row;
        seed = 32'hfcb404fd;
        fill_table();
        reset  = 1'b1;
        i_rx   = 1'b1;
        i_data = row_word[0];
        repeat (2) @(negedge clk_in);
        reset = 1'b0;
        check_reset_state();
        for (row = 0; row < NUM_ROWS; row++) begin
            case (row_action[row])
                SEND_CMD: begin
                    i_data = row_word[row];
                    send_serial(row_cmd[row]);
                    check_echo(row_cmd[row]);
                end
                EXPECT_SNAPSHOT: begin
                    check_snapshot(row_word[row], row_change[row]);
                end
                EXPECT_SILENCE: begin
                    check_silence();
                end
                default: begin
                    abort_run("stimulus table holds an unknown action");
                end
            endcase
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== uart_debug_port.sv ====
module uart_debug_port (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic [dbg_pkg::DATA_WIDTH-1:0] i_data,
    input  logic                           i_rx,
    output logic                           o_tx,
    output logic [7:0]                     o_cmd_data,
    output logic                           o_cmd_valid,
    output logic                           o_rx_busy
);

    logic pause;
    logic snap_request;

    tx_byte_if tx_bus ();

    // received bytes go to the decoder and out to the echo ports
    uart_rx i_uart_rx (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_rx    (i_rx),
        .o_data  (o_cmd_data),
        .o_valid (o_cmd_valid),
        .o_busy  (o_rx_busy)
    );

    dbg_command_decoder i_dbg_command_decoder (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_cmd_data     (o_cmd_data),
        .i_cmd_valid    (o_cmd_valid),
        .o_pause        (pause),
        .o_snap_request (snap_request)
    );

    dbg_snapshot_sequencer i_dbg_snapshot_sequencer (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_data         (i_data),
        .i_pause        (pause),
        .i_snap_request (snap_request),
        .tx             (tx_bus.source)
    );

    uart_tx i_uart_tx (
        .clk_in (clk_in),
        .reset  (reset),
        .tx     (tx_bus.sink),
        .o_tx   (o_tx)
    );

endmodule

// ==== dbg_snapshot_sequencer.sv ====
module dbg_snapshot_sequencer (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic [dbg_pkg::DATA_WIDTH-1:0] i_data,
    input  logic                           i_pause,
    input  logic                           i_snap_request,
    tx_byte_if.source                      tx
);
    import dbg_pkg::*;

    logic [TIMER_WIDTH-1:0] period_cnt;
    logic                   period_hit;
    logic                   trigger;
    snap_state_e            state;
    logic [POS_WIDTH-1:0]   byte_pos;
    logic                   do_close;
    logic [DATA_WIDTH-1:0]  data_copy;
    logic [7:0]             next_byte;

    // free-running, keeps counting while paused or busy
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            period_cnt <= '0;
        end else if (period_hit) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign period_hit = (period_cnt == TIMER_WIDTH'(SNAPSHOT_PERIOD - 1));
    assign trigger    = (period_hit && !i_pause) || i_snap_request;

    // copy is shifted up after each byte, so the current byte sits on top
    assign next_byte = do_close ? NEWLINE_BYTE : data_copy[DATA_WIDTH-1 -: 8];

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state       <= SNAP_IDLE;
            byte_pos    <= '0;
            do_close    <= 1'b0;
            tx.tx_start <= 1'b0;
        end else begin
            tx.tx_start <= 1'b0;
            case (state)
                SNAP_IDLE: begin
                    // triggers seen in any other state are dropped
                    if (trigger) begin
                        byte_pos <= POS_WIDTH'(BYTES_PER_WORD);
                        do_close <= 1'b0;
                        state    <= SNAP_LOAD;
                    end
                end
                SNAP_LOAD: begin
                    if (byte_pos == '0) begin
                        do_close <= 1'b1;
                    end
                    state <= SNAP_SEND;
                end
                SNAP_SEND: begin
                    if (!tx.tx_busy) begin
                        tx.tx_start <= 1'b1;
                        state       <= SNAP_WAIT;
                    end
                end
                SNAP_WAIT: begin
                    // done marks the cycle busy drops at the end of the frame
                    if (tx.tx_done) begin
                        if (do_close) begin
                            do_close <= 1'b0;
                            state    <= SNAP_IDLE;
                        end else begin
                            byte_pos <= byte_pos - 1'b1;
                            state    <= SNAP_LOAD;
                        end
                    end
                end
                default: state <= SNAP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == SNAP_IDLE && trigger) begin
            data_copy <= i_data;
        end else if (state == SNAP_WAIT && tx.tx_done && !do_close) begin
            data_copy <= {data_copy[DATA_WIDTH-9:0], 8'h00};
        end
        if (state == SNAP_SEND && !tx.tx_busy) begin
            tx.tx_data <= next_byte;
        end
    end

endmodule

// ==== dbg_command_decoder.sv ====
module dbg_command_decoder (
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] i_cmd_data,
    input  logic       i_cmd_valid,
    output logic       o_pause,
    output logic       o_snap_request
);
    import dbg_pkg::*;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            o_pause        <= 1'b0;
            o_snap_request <= 1'b0;
        end else begin
            o_snap_request <= 1'b0;
            if (i_cmd_valid) begin
                case (i_cmd_data)
                    OP_PAUSE: begin
                        o_pause <= 1'b1;
                    end
                    OP_RESUME: begin
                        o_pause <= 1'b0;
                    end
                    // one-shot, independent of pause
                    OP_SNAPSHOT: begin
                        o_snap_request <= 1'b1;
                    end
                    default: begin
                        // other bytes only show up on the echo port
                        o_pause <= o_pause;
                    end
                endcase
            end
        end
    end

endmodule

// ==== uart_tx.sv ====
module uart_tx (
    input  logic   clk_in,
    input  logic   reset,
    tx_byte_if.sink tx,
    output logic   o_tx
);
    import dbg_pkg::*;

    uart_state_e              state;
    logic [TICK_WIDTH-1:0]    tick_cnt;
    logic [BIT_IDX_WIDTH-1:0] bit_idx;
    logic [7:0]               tx_shift;
    logic                     bit_end;

    assign bit_end = (tick_cnt == TICK_WIDTH'(TICKS_PER_BIT - 1));

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state      <= UART_IDLE;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            o_tx       <= 1'b1;
            tx.tx_busy <= 1'b0;
            tx.tx_done <= 1'b0;
        end else begin
            tx.tx_done <= 1'b0;
            case (state)
                UART_IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    // start bit goes out on the next cycle
                    if (tx.tx_start) begin
                        o_tx       <= 1'b0;
                        tx.tx_busy <= 1'b1;
                        state      <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        o_tx     <= tx_shift[0];
                        state    <= UART_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == '1) begin
                            o_tx  <= 1'b1;
                            state <= UART_STOP;
                        end else begin
                            o_tx <= tx_shift[0];
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        tick_cnt   <= '0;
                        tx.tx_busy <= 1'b0;
                        tx.tx_done <= 1'b1;
                        state      <= UART_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // bit 0 of the shifter is always the next data bit to drive
    always_ff @(posedge clk_in) begin
        if (state == UART_IDLE && tx.tx_start) begin
            tx_shift <= tx.tx_data;
        end else if (bit_end && (state == UART_START || state == UART_DATA)) begin
            tx_shift <= {1'b0, tx_shift[7:1]};
        end
    end

endmodule

// ==== uart_rx.sv ====
module uart_rx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_rx,
    output logic [7:0] o_data,
    output logic       o_valid,
    output logic       o_busy
);
    import dbg_pkg::*;

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
    logic                     rx_fall;
    logic                     half_end;
    logic                     bit_end;
    uart_state_e              state;
    logic [TICK_WIDTH-1:0]    tick_cnt;
    logic [BIT_IDX_WIDTH-1:0] bit_idx;
    logic [7:0]               rx_shift;

    assign rx_fall  = rx_prev & ~rx_sync;
    assign half_end = (tick_cnt == TICK_WIDTH'(HALF_BIT_TICKS - 1));
    assign bit_end  = (tick_cnt == TICK_WIDTH'(TICKS_PER_BIT - 1));

    // two-stage synchronizer, idle line is high
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state    <= UART_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_valid  <= 1'b0;
            o_busy   <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                UART_IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_fall) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (half_end) begin
                        tick_cnt <= '0;
                        // a glitch shorter than half a bit is ignored
                        if (!rx_sync) begin
                            o_busy <= 1'b1;
                            state  <= UART_DATA;
                        end else begin
                            state <= UART_IDLE;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == '1) begin
                            state <= UART_STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    // byte is handed over at mid stop bit
                    if (bit_end) begin
                        tick_cnt <= '0;
                        o_valid  <= 1'b1;
                        o_busy   <= 1'b0;
                        state    <= UART_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk_in) begin
        if (state == UART_DATA && bit_end) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (state == UART_STOP && bit_end) begin
            o_data <= rx_shift;
        end
    end

endmodule

// ==== tx_byte_if.sv ====
interface tx_byte_if;

    // start is a single-cycle request, only legal while busy is low
    logic       tx_start;
    logic [7:0] tx_data;
    // busy rises the cycle after start and drops with done
    logic       tx_busy;
    logic       tx_done;

    modport source (
        output tx_start,
        output tx_data,
        input  tx_busy,
        input  tx_done
    );

    modport sink (
        input  tx_start,
        input  tx_data,
        output tx_busy,
        output tx_done
    );

endinterface

// ==== dbg_pkg.sv ====
package dbg_pkg;

    // snapshot word, sent as whole bytes
    localparam int DATA_WIDTH = 16;
    localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
    localparam int POS_WIDTH = $clog2(BYTES_PER_WORD + 1);

    // uart bit timing, kept short for simulation
    localparam int TICKS_PER_BIT = 8;
    localparam int HALF_BIT_TICKS = TICKS_PER_BIT / 2;
    localparam int TICK_WIDTH = $clog2(TICKS_PER_BIT);
    localparam int BIT_IDX_WIDTH = 3;

    // cycles between periodic snapshots
    localparam int SNAPSHOT_PERIOD = 1200;
    localparam int TIMER_WIDTH = $clog2(SNAPSHOT_PERIOD);

    localparam logic [7:0] NEWLINE_BYTE = 8'h0A;

    // host command bytes ('P', 'R', 'S')
    typedef enum logic [7:0] {
        OP_PAUSE    = 8'h50,
        OP_RESUME   = 8'h52,
        OP_SNAPSHOT = 8'h53
    } dbg_opcode_e;

    typedef enum logic [4:0] {
        SNAP_IDLE = 5'b00001,
        SNAP_LOAD = 5'b00010,
        SNAP_SEND = 5'b00100,
        SNAP_WAIT = 5'b01000
    } snap_state_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage
